// ==== ex_stage.f ====
+incdir+test
design/ex_pkg.sv
design/alu_unit.sv
design/ex_result_fifo.sv
design/ex_mem_latch.sv
design/ex_stage.sv
test/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f ex_stage.f --top-module ex_stage_tb \
	&& ./obj_dir/Vex_stage_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
	|| { echo "simulation failed" >&2; exit 1; }

// ==== test/ex_ref_model.svh ====
// reference model and random request builder for the execute stage testbench
// included inside the testbench module body

	logic [31:0] rng_state = 32'hff0e;

	// xorshift32 step
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// kind 0 alu ops, 1 jumps and branches, 2 loads and stores, else any op
	function automatic ex_req_t rand_req(input int kind);
		ex_req_t     r;
		logic [31:0] pick;
		pick = next_rand();
		case (kind)
			0: r.op = ex_op_e'(6'(pick % 27));   // add through auipc
			1: r.op = ex_op_e'((pick[2:0] < 3'd2) ? 6'd27 + 6'(pick[2:0]) : 6'd38 + 6'(pick[2:0]));
			2: r.op = ex_op_e'(6'd29 + 6'(pick % 11));   // lb through sd
			default: r.op = ex_op_e'(6'(pick % 46));
		endcase
		r.pc[63:32] = next_rand();
		r.pc[31:0] = next_rand() & 32'hffff_fffc;
		r.rs1_val[63:32] = next_rand();
		r.rs1_val[31:0] = next_rand();
		r.rs2_val[63:32] = next_rand();
		r.rs2_val[31:0] = next_rand();
		if (pick[9:8] == 2'b00)
			r.rs2_val = r.rs1_val;   // equal operands now and then so that branches get taken
		r.imm = next_rand();
		r.wb_reg = pick[14:10];
		return r;
	endfunction

	// expected result of one request
	function automatic ex_res_t expect_res(input ex_req_t r);
		ex_res_t     e;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] i;
		logic [63:0] u;
		a = r.rs1_val;
		b = r.rs2_val;
		i = {{52{r.imm[11]}}, r.imm[11:0]};
		u = {{32{r.imm[31]}}, r.imm[31:12], 12'h000};
		e = '0;
		e.pc = r.pc;
		e.wb_reg = r.wb_reg;
		e.reg_write = !(r.op inside {[op_sb:op_sd], [op_beq:op_bgeu]});
		e.mem_read = r.op inside {[op_lb:op_lwu]};
		e.mem_write = r.op inside {[op_sb:op_sd]};
		if (e.mem_read || e.mem_write)
			e.result = a + i;   // effective address
		case (r.op)
			op_add, op_addw: e.result = a + b;
			op_sub, op_subw: e.result = a - b;
			op_addi, op_addiw: e.result = a + i;
			op_and: e.result = a & b;
			op_andi: e.result = a & i;
			op_or: e.result = a | b;
			op_ori: e.result = a | i;
			op_xor: e.result = a ^ b;
			op_xori: e.result = a ^ i;
			op_sll: e.result = a << b[5:0];
			op_slli: e.result = a << r.imm[5:0];
			op_srl: e.result = a >> b[5:0];
			op_srli: e.result = a >> r.imm[5:0];
			op_sra: e.result = $signed(a) >>> b[5:0];
			op_srai: e.result = $signed(a) >>> r.imm[5:0];
			op_sllw: e.result = a << b[4:0];
			op_srlw: e.result = {32'h0, a[31:0]} >> b[4:0];
			op_sraw: e.result = $signed({{32{a[31]}}, a[31:0]}) >>> b[4:0];
			op_slt: e.result = {63'h0, $signed(a) < $signed(b)};
			op_slti: e.result = {63'h0, $signed(a) < $signed(i)};
			op_sltu: e.result = {63'h0, a < b};
			op_sltiu: e.result = {63'h0, a < i};
			op_lui: e.result = u;
			op_auipc: e.result = r.pc + u;
			op_jal, op_jalr: e.result = r.pc + 64'd4;   // link
			op_beq: e.branch_taken = (a == b);
			op_bne: e.branch_taken = (a != b);
			op_blt: e.branch_taken = ($signed(a) < $signed(b));
			op_bge: e.branch_taken = !($signed(a) < $signed(b));
			op_bltu: e.branch_taken = (a < b);
			op_bgeu: e.branch_taken = !(a < b);
			op_lb, op_lbu, op_sb: e.size = size_byte;
			op_lh, op_lhu, op_sh: e.size = size_half;
			op_lw, op_lwu, op_sw: e.size = size_word;
			op_ld, op_sd: e.size = size_double;
			default: e.size = size_none;
		endcase
		if (r.op inside {op_jal, op_jalr})
			e.branch_taken = 1'b1;
		if (r.op == op_jal)
			e.branch_target = r.pc + i;
		else if (r.op == op_jalr)
			e.branch_target = (a + i) & ~64'd1;
		else if (r.op inside {[op_beq:op_bgeu]})
			e.branch_target = e.branch_taken ? r.pc + i : r.pc;
		// W forms sign-extend the low word
		if (r.op inside {op_addw, op_addiw, op_subw, op_sllw, op_srlw, op_sraw})
			e.result = {{32{e.result[31]}}, e.result[31:0]};
		e.store_data = e.mem_write ? b : '0;
		return e;
	endfunction

// ==== test/ex_stage_tb.sv ====
// drives random requests into the execute stage and checks every result against a model
// built and run with Verilator through run_sim.sh
`timescale 1ns/1ps

module ex_stage_tb;

	import ex_pkg::*;

	localparam int DEPTH = 4;

	logic    clk;
	logic    rst;
	logic    req_valid;
	ex_req_t req;
	logic    mem_stall;
	logic    req_ready;
	logic    out_valid;
	ex_res_t out;

	ex_res_t exp_q[$];   // expected results, oldest first
	ex_res_t expected;
	int      errors = 0;
	int      checks = 0;
	logic    timed_out = 1'b0;

	`include "ex_ref_model.svh"

	ex_stage #(.DEPTH(DEPTH)) u_ex_stage (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_res(input string name, input ex_res_t got, input ex_res_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// scoreboard on the values just before each rising edge
	always @(posedge clk)
	begin
		if (!rst && req_valid && req_ready)
			exp_q.push_back(expect_res(req));
		if (!rst && out_valid && !mem_stall)
		begin
			if (exp_q.size() == 0)
			begin
				$display("output item appeared with no request outstanding");
				errors++;
			end
			else
			begin
				expected = exp_q.pop_front();
				check_res("out", out, expected);
			end
		end
		if (exp_q.size() > DEPTH + 1)
		begin
			$display("%0d items in flight, more than the queue and latch can hold", exp_q.size());
			errors++;
		end
	end

	// send n requests, then release the stall and wait until every result is out
	// a stall of 100 percent ends the sending once req_ready drops
	task automatic run_test(input string name, input int n, input int kind,
		input int stall_pct, input int valid_pct);
		int sent;
		int cycles;
		int err0;
		sent = 0;
		cycles = 0;
		err0 = errors;
		while (sent < n && (stall_pct < 100 || req_ready) && cycles < 20000)
		begin
			@(posedge clk);
			cycles++;
			if (req_valid && req_ready)
				sent++;
			if (!req_valid || req_ready)   // hold a request until taken
			begin
				req_valid <= (sent < n) && ((next_rand() % 100) < valid_pct);
				req <= rand_req(kind);
			end
			mem_stall <= (next_rand() % 100) < stall_pct;
		end
		if (cycles >= 20000)
		begin
			$display("%s: timeout, requests were not accepted", name);
			timed_out = 1'b1;
		end
		if (stall_pct == 100)
		begin
			@(negedge clk);
			check_flag("req_ready", req_ready, 1'b0);
		end
		@(posedge clk);
		req_valid <= 1'b0;
		mem_stall <= 1'b0;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 2000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%s: timeout, %0d results never came out", name, exp_q.size());
			timed_out = 1'b1;
		end
		$display("%s: %0d requests accepted, %0d errors", name, sent, errors - err0);
	endtask

	initial
	begin
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		mem_stall = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
		$display("reset: %0d errors", errors);
		run_test("alu ops", 300, 0, 0, 100);
		run_test("jumps and branches", 200, 1, 0, 80);
		run_test("loads and stores", 200, 2, 0, 80);
		run_test("back-pressure", 50, 3, 100, 100);
		run_test("random stall", 500, 3, 40, 60);
		$display("6 tests, %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : ex_stage_tb

// ==== design/ex_stage.sv ====
// execute stage top: ALU, result queue and memory stage latch
// req_ready reflects the credits left in the ALU
`timescale 1ns/1ps

module ex_stage
#(
	parameter int DEPTH = 4
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic            req_valid,
	input  ex_pkg::ex_req_t req,
	input  logic            mem_stall,
	output logic            req_ready,
	output logic            out_valid,
	output ex_pkg::ex_res_t out
);

	import ex_pkg::*;

	logic    push;
	ex_res_t push_data;
	logic    credit;
	logic    head_valid;
	ex_res_t head;
	logic    pop;

	alu_unit #(
		.DEPTH(DEPTH)
	) u_alu_unit (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.credit    (credit),
		.req_ready (req_ready),
		.push      (push),
		.push_data (push_data)
	);

	ex_result_fifo #(
		.DEPTH(DEPTH)
	) u_ex_result_fifo (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.head_valid (head_valid),
		.head       (head),
		.credit     (credit)
	);

	ex_mem_latch u_ex_mem_latch (
		.clk        (clk),
		.rst        (rst),
		.head_valid (head_valid),
		.head       (head),
		.mem_stall  (mem_stall),
		.pop        (pop),
		.out_valid  (out_valid),
		.out        (out)
	);

endmodule : ex_stage

// ==== design/ex_mem_latch.sv ====
// one-entry output register toward the memory stage
`timescale 1ns/1ps

module ex_mem_latch
(
	input  logic            clk,
	input  logic            rst,
	input  logic            head_valid,
	input  ex_pkg::ex_res_t head,
	input  logic            mem_stall,
	output logic            pop,
	output logic            out_valid,
	output ex_pkg::ex_res_t out
);

	logic consumed;

	assign consumed = out_valid & ~mem_stall;

	// reload when empty or when the current item leaves
	assign pop = head_valid & (~out_valid | consumed);

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (pop)
			out_valid <= 1'b1;
		else if (consumed)
			out_valid <= 1'b0;
	end

	// held while the memory stage stalls
	always_ff @(posedge clk)
	begin
		if (pop)
			out <= head;
	end

endmodule : ex_mem_latch

// ==== design/ex_result_fifo.sv ====
// result queue between the ALU and the output latch
// returns one credit to the ALU for every entry popped
`timescale 1ns/1ps

module ex_result_fifo
#(
	parameter int DEPTH = 4
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic            push,
	input  ex_pkg::ex_res_t push_data,
	input  logic            pop,
	output logic            head_valid,
	output ex_pkg::ex_res_t head,
	output logic            credit
);

	import ex_pkg::*;

	localparam int ptr_w = $clog2(DEPTH);
	localparam int cnt_w = $clog2(DEPTH + 1);

	ex_res_t          mem [DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_pop;

	assign head_valid = (count != '0);
	assign head       = mem[rd_ptr];
	assign do_pop     = pop & head_valid;

	// the ALU credits keep a push from ever meeting a full queue
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count  <= count + cnt_w'(push) - cnt_w'(do_pop);
			credit <= do_pop;   // one cycle behind the pop
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule : ex_result_fifo

// ==== design/alu_unit.sv ====
// execute stage ALU with credit-gated request acceptance
// one request per cycle in, registered result out one clock later
`timescale 1ns/1ps

module alu_unit
#(
	parameter int DEPTH = 4
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic            req_valid,
	input  ex_pkg::ex_req_t req,
	input  logic            credit,
	output logic            req_ready,
	output logic            push,
	output ex_pkg::ex_res_t push_data
);

	import ex_pkg::*;

	localparam int cred_w = $clog2(DEPTH + 1);

	logic [cred_w-1:0] credits;
	logic              accept;
	logic [xlen-1:0]   imm_sx;
	logic [xlen-1:0]   upper_imm;
	logic [xlen-1:0]   addr_sum;   // rs1 + imm
	logic [xlen-1:0]   pc_imm;     // pc + imm
	logic [5:0]        shamt;
	logic [4:0]        shamt_w;
	logic              br_cond;
	ex_res_t           res;

	// sign-extend a 32 bit answer
	function automatic logic [xlen-1:0] sext_w(input logic [31:0] v);
		return {{(xlen - 32){v[31]}}, v};
	endfunction

	assign req_ready = (credits != '0);
	assign accept    = req_valid & req_ready;

	// one credit per queue slot
	always_ff @(posedge clk)
	begin
		if (rst)
			credits <= cred_w'(DEPTH);
		else
			credits <= credits + cred_w'(credit) - cred_w'(accept);
	end

	assign imm_sx    = {{(xlen - 12){req.imm[11]}}, req.imm[11:0]};
	assign upper_imm = sext_w({req.imm[31:12], 12'h000});
	assign addr_sum  = req.rs1_val + imm_sx;
	assign pc_imm    = req.pc + imm_sx;
	assign shamt     = req.rs2_val[5:0];
	assign shamt_w   = req.rs2_val[4:0];

	always_comb
	begin
		case (req.op)
			op_beq:  br_cond = (req.rs1_val == req.rs2_val);
			op_bne:  br_cond = (req.rs1_val != req.rs2_val);
			op_blt:  br_cond = ($signed(req.rs1_val) < $signed(req.rs2_val));
			op_bge:  br_cond = ($signed(req.rs1_val) >= $signed(req.rs2_val));
			op_bltu: br_cond = (req.rs1_val < req.rs2_val);
			op_bgeu: br_cond = (req.rs1_val >= req.rs2_val);
			default: br_cond = 1'b0;
		endcase
	end

	always_comb
	begin
		res = '0;
		res.pc = req.pc;           // pc and wb_reg travel with every op
		res.wb_reg = req.wb_reg;
		res.reg_write = 1'b1;
		case (req.op)
			op_add:   res.result = req.rs1_val + req.rs2_val;
			op_sub:   res.result = req.rs1_val - req.rs2_val;
			op_addi:  res.result = addr_sum;
			op_addw:  res.result = sext_w(req.rs1_val[31:0] + req.rs2_val[31:0]);
			op_addiw: res.result = sext_w(req.rs1_val[31:0] + imm_sx[31:0]);
			op_subw:  res.result = sext_w(req.rs1_val[31:0] - req.rs2_val[31:0]);
			op_and:   res.result = req.rs1_val & req.rs2_val;
			op_andi:  res.result = req.rs1_val & imm_sx;
			op_or:    res.result = req.rs1_val | req.rs2_val;
			op_ori:   res.result = req.rs1_val | imm_sx;
			op_xor:   res.result = req.rs1_val ^ req.rs2_val;
			op_xori:  res.result = req.rs1_val ^ imm_sx;
			op_sll:   res.result = req.rs1_val << shamt;
			op_slli:  res.result = req.rs1_val << req.imm[5:0];
			op_srl:   res.result = req.rs1_val >> shamt;
			op_srli:  res.result = req.rs1_val >> req.imm[5:0];
			op_sra:   res.result = $signed(req.rs1_val) >>> shamt;
			op_srai:  res.result = $signed(req.rs1_val) >>> req.imm[5:0];
			op_sllw:  res.result = sext_w(req.rs1_val[31:0] << shamt_w);
			op_srlw:  res.result = sext_w(req.rs1_val[31:0] >> shamt_w);
			op_sraw:  res.result = sext_w($signed(req.rs1_val[31:0]) >>> shamt_w);
			op_slt:   res.result = xlen'($signed(req.rs1_val) < $signed(req.rs2_val));
			op_slti:  res.result = xlen'($signed(req.rs1_val) < $signed(imm_sx));
			op_sltu:  res.result = xlen'(req.rs1_val < req.rs2_val);
			op_sltiu: res.result = xlen'(req.rs1_val < imm_sx);
			op_lui:   res.result = upper_imm;
			op_auipc: res.result = req.pc + upper_imm;
			op_jal, op_jalr:
			begin
				res.result = req.pc + xlen'(4);   // link value
				res.branch_taken = 1'b1;
				res.branch_target = (req.op == op_jal) ? pc_imm : {addr_sum[xlen-1:1], 1'b0};
			end
			op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld:
			begin
				res.result = addr_sum;
				res.mem_read = 1'b1;
				case (req.op)
					op_lb, op_lbu: res.size = size_byte;
					op_lh, op_lhu: res.size = size_half;
					op_lw, op_lwu: res.size = size_word;
					default:       res.size = size_double;
				endcase
			end
			op_sb, op_sh, op_sw, op_sd:
			begin
				res.reg_write = 1'b0;
				res.result = addr_sum;
				res.mem_write = 1'b1;
				res.store_data = req.rs2_val;
				case (req.op)
					op_sb:   res.size = size_byte;
					op_sh:   res.size = size_half;
					op_sw:   res.size = size_word;
					default: res.size = size_double;
				endcase
			end
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
			begin
				res.reg_write = 1'b0;
				res.branch_taken = br_cond;
				res.branch_target = br_cond ? pc_imm : req.pc;  // fall through keeps pc
			end
			default:  res.reg_write = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			push <= 1'b0;
		else
			push <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			push_data <= res;
	end

endmodule : alu_unit

// ==== design/ex_pkg.sv ====
// shared types for the execute stage
// request from decode, result toward the memory stage
package ex_pkg;

	localparam int xlen = 64;
	localparam int reg_addr_w = 5;

	// kept RV64I operations
	typedef enum logic [5:0] {
		op_add, op_sub, op_addi, op_addw, op_addiw, op_subw,
		op_and, op_andi, op_or, op_ori, op_xor, op_xori,
		op_sll, op_slli, op_srl, op_srli, op_sra, op_srai,
		op_sllw, op_srlw, op_sraw,
		op_slt, op_slti, op_sltu, op_sltiu,
		op_lui, op_auipc, op_jal, op_jalr,
		op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
		op_sb, op_sh, op_sw, op_sd,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
	} ex_op_e;

	// access size of a load or store
	typedef enum logic [2:0] {
		size_none   = 3'd0,
		size_byte   = 3'd1,
		size_half   = 3'd2,
		size_word   = 3'd3,
		size_double = 3'd4
	} mem_size_e;

	typedef struct packed {
		ex_op_e                op;
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       rs1_val;
		logic [xlen-1:0]       rs2_val;
		logic [31:0]           imm;     // raw immediate field
		logic [reg_addr_w-1:0] wb_reg;
	} ex_req_t;

	typedef struct packed {
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] wb_reg;
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		mem_size_e             size;
		logic [xlen-1:0]       result;     // alu value, link value or address
		logic [xlen-1:0]       store_data;
		logic                  branch_taken;
		logic [xlen-1:0]       branch_target;
	} ex_res_t;

endpackage : ex_pkg
